//--- run.sh
#!/bin/bash
verilator --binary --timing --assert --top-module ex_tb -f src.f -o ex_tb_sim > build.log 2>&1 &&
./obj_dir/ex_tb_sim > sim.log 2>&1 ||
{ echo "build or simulation error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

//--- sim/ex_assertions.sv
/* output legality of the execute slice; bound into ex_top */
module ex_assertions (
    input logic       clk,
    input logic       reset,
    input logic       dmem_valid,
    input logic       wb_valid,
    input logic [3:0] dmem_rmask,
    input logic [3:0] dmem_wmask
);

    // registers are cleared by the edge that sees reset
    a_reset_clear: assert property (@(posedge clk)
        reset |=> (!dmem_valid && !wb_valid && dmem_rmask == 4'b0 && dmem_wmask == 4'b0))
        else $error("outputs not cleared after reset");

    a_masks_exclusive: assert property (@(posedge clk)
        !(dmem_rmask != 4'b0 && dmem_wmask != 4'b0))
        else $error("read and write mask active together");

endmodule

bind ex_top ex_assertions u_ex_assertions (
    .clk        (clk),
    .reset      (reset),
    .dmem_valid (dmem_valid),
    .wb_valid   (wb_valid),
    .dmem_rmask (dmem_rmask),
    .dmem_wmask (dmem_wmask)
);

//--- sim/ex_checker.sv
/* compares dmem and write-back events against expectations queued at acceptance;
   an event counts only on an edge with move high, since outputs hold while stalled */
module ex_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        move,
    input  logic        dmem_valid,
    input  logic [31:0] dmem_addr,
    input  logic [3:0]  dmem_rmask,
    input  logic [3:0]  dmem_wmask,
    input  logic [31:0] dmem_wdata,
    input  logic        wb_valid,
    input  logic [4:0]  wb_rd,
    input  logic [31:0] wb_data,
    input  logic        exp_push,
    input  logic        exp_dmem,
    input  logic [31:0] exp_addr,
    input  logic [3:0]  exp_rmask,
    input  logic [3:0]  exp_wmask,
    input  logic [31:0] exp_wdata,
    input  logic        exp_wb,
    input  logic [4:0]  exp_rd,
    input  logic [31:0] exp_wbdata,
    output int          err_count,
    output logic        idle
);

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } dmem_exp_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_exp_t;

    dmem_exp_t    dmem_q [$];
    wb_exp_t      wb_q [$];
    dmem_exp_t    d_exp;
    wb_exp_t      w_exp;
    logic [110:0] outs;
    logic [110:0] last_outs;
    logic         stalled;

    assign outs = {dmem_valid, dmem_addr, dmem_rmask, dmem_wmask, dmem_wdata,
                   wb_valid, wb_rd, wb_data};

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            err_count++;
        end
    endtask

    initial begin
        err_count = 0;
        idle = 1'b1;
        stalled = 1'b0;
        last_outs = '0;
    end

    always @(posedge clk) begin
        // a stall on the previous edge leaves every output unchanged
        if (stalled && outs !== last_outs) begin
            $display("outputs changed across a cycle with move low");
            err_count++;
        end
        stalled = !reset && !move;
        last_outs = outs;
        if (!reset && move) begin
            if (dmem_valid) begin
                if (dmem_q.size() == 0) begin
                    $display("dmem request appeared with no memory operation pending");
                    err_count++;
                end else begin
                    d_exp = dmem_q.pop_front();
                    check_val("dmem_addr", dmem_addr, d_exp.addr);
                    check_val("dmem_rmask", {28'b0, dmem_rmask}, {28'b0, d_exp.rmask});
                    check_val("dmem_wmask", {28'b0, dmem_wmask}, {28'b0, d_exp.wmask});
                    check_val("dmem_wdata", dmem_wdata, d_exp.wdata);
                end
            end
            if (wb_valid) begin
                if (wb_q.size() == 0) begin
                    $display("write-back appeared with no register write pending");
                    err_count++;
                end else begin
                    w_exp = wb_q.pop_front();
                    check_val("wb_rd", {27'b0, wb_rd}, {27'b0, w_exp.rd});
                    check_val("wb_data", wb_data, w_exp.data);
                end
            end
            // new op accepted on this same edge
            if (exp_push && exp_dmem) begin
                dmem_q.push_back({exp_addr, exp_rmask, exp_wmask, exp_wdata});
            end
            if (exp_push && exp_wb) begin
                wb_q.push_back({exp_rd, exp_wbdata});
            end
        end
        idle = (dmem_q.size() == 0) && (wb_q.size() == 0);
    end

endmodule

//--- sim/ex_tb.sv
/* table-driven testbench for ex_top; move is random so rows see stalls.
   expected values are worked out by hand from register contents of earlier rows */
module ex_tb;
    import rv32i_types::*;

    typedef struct packed {
        logic [31:0] pc;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic [31:0] imm;
        alu_op_t     aluop;
        cmp_op_t     cmpop;
        alu_a_sel_t  a_sel;
        alu_b_sel_t  b_sel;
        cmp_b_sel_t  c_sel;
        logic        mem_we;
        logic        mem_re;
        logic [2:0]  funct3;
        rd_sel_t     rd_sel;
        logic        rd_we;
        logic        e_dmem;
        logic [31:0] e_addr;
        logic [3:0]  e_rmask;
        logic [3:0]  e_wmask;
        logic [31:0] e_wdata;
        logic        e_wb;
        logic [31:0] e_wbdata;
    } row_t;

    logic        clk;
    logic        reset;
    logic        move;
    logic        op_valid;
    logic [31:0] op_pc;
    reg_addr_t   op_rs1;
    reg_addr_t   op_rs2;
    reg_addr_t   op_rd;
    logic [31:0] op_imm;
    alu_op_t     op_aluop;
    cmp_op_t     op_cmpop;
    alu_a_sel_t  op_alu_a_sel;
    alu_b_sel_t  op_alu_b_sel;
    cmp_b_sel_t  op_cmp_sel;
    logic        op_mem_we;
    logic        op_mem_re;
    logic [2:0]  op_funct3;
    rd_sel_t     op_rd_sel;
    logic        op_rd_we;
    logic        dmem_valid;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic        wb_valid;
    reg_addr_t   wb_rd;
    logic [31:0] wb_data;

    logic        exp_push;
    logic        exp_dmem;
    logic [31:0] exp_addr;
    logic [3:0]  exp_rmask;
    logic [3:0]  exp_wmask;
    logic [31:0] exp_wdata;
    logic        exp_wb;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wbdata;
    int          err_count;
    logic        idle;

    row_t   rows [64];
    int     n_rows;
    int     limit;
    int     cycles;
    integer seed;
    logic   accepted;

    ex_top #(.reg_count(32)) u_dut (.*);

    ex_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic row_t blank_row();
        row_t r;
        r = '0;
        r.pc = 32'h100 + 4 * n_rows;
        r.aluop = alu_add;
        r.cmpop = beq;
        r.a_sel = rs1_out;
        r.b_sel = imm_out;
        r.c_sel = rs2_out_cmp;
        r.rd_sel = alu_out_rd;
        return r;
    endfunction

    task automatic add_row(input row_t r);
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic alu_row(input alu_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input logic use_imm, input logic [31:0] imm,
                           input logic [31:0] result);
        row_t r;
        r = blank_row();
        r.aluop = op;
        r.rd = rd;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.imm = imm;
        r.b_sel = use_imm ? imm_out : rs2_out;
        r.rd_we = 1'b1;
        r.e_wb = 1'b1;
        r.e_wbdata = result;
        add_row(r);
    endtask

    task automatic cmp_row(input cmp_op_t op, input reg_addr_t rd, input reg_addr_t rs1,
                           input reg_addr_t rs2, input logic use_imm, input logic [31:0] imm,
                           input logic taken);
        row_t r;
        r = blank_row();
        r.cmpop = op;
        r.rd = rd;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.imm = imm;
        r.c_sel = use_imm ? imm_out_cmp : rs2_out_cmp;
        r.rd_sel = ext_br;
        r.rd_we = 1'b1;
        r.e_wb = 1'b1;
        r.e_wbdata = {31'b0, taken};
        add_row(r);
    endtask

    // link value is pc plus 4
    task automatic link_row(input reg_addr_t rd);
        row_t r;
        r = blank_row();
        r.rd = rd;
        r.a_sel = pc_out;
        r.b_sel = const4;
        r.rd_we = 1'b1;
        r.e_wb = 1'b1;
        r.e_wbdata = r.pc + 32'd4;
        add_row(r);
    endtask

    task automatic store_row(input logic [2:0] f3, input reg_addr_t rs1, input reg_addr_t rs2,
                             input logic [31:0] imm, input logic [31:0] addr,
                             input logic [3:0] wmask, input logic [31:0] wdata);
        row_t r;
        r = blank_row();
        r.funct3 = f3;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.imm = imm;
        r.mem_we = 1'b1;
        r.e_dmem = 1'b1;
        r.e_addr = addr;
        r.e_wmask = wmask;
        r.e_wdata = wdata;
        add_row(r);
    endtask

    task automatic load_row(input logic [2:0] f3, input reg_addr_t rd, input reg_addr_t rs1,
                            input logic [31:0] imm, input logic [31:0] addr,
                            input logic [3:0] rmask);
        row_t r;
        r = blank_row();
        r.funct3 = f3;
        r.rd = rd;
        r.rs1 = rs1;
        r.imm = imm;
        r.mem_re = 1'b1;
        r.rd_we = 1'b1;
        r.e_dmem = 1'b1;
        r.e_addr = addr;
        r.e_rmask = rmask;
        add_row(r);
    endtask

    task automatic build_table();
        alu_row(alu_add, 5'd1, 5'd0, 5'd0, 1'b1, 32'h5, 32'h5);
        alu_row(alu_add, 5'd2, 5'd0, 5'd0, 1'b1, 32'hffff_fff0, 32'hffff_fff0);
        // x2 one back, x1 two back
        alu_row(alu_sub, 5'd3, 5'd1, 5'd2, 1'b0, 32'h0, 32'h15);
        alu_row(alu_sll, 5'd4, 5'd1, 5'd0, 1'b1, 32'h4, 32'h50);
        alu_row(alu_slt, 5'd5, 5'd2, 5'd1, 1'b0, 32'h0, 32'h1);
        alu_row(alu_sltu, 5'd6, 5'd2, 5'd1, 1'b0, 32'h0, 32'h0);
        alu_row(alu_xor, 5'd7, 5'd1, 5'd0, 1'b1, 32'hff, 32'hfa);
        alu_row(alu_srl, 5'd8, 5'd2, 5'd0, 1'b1, 32'h4, 32'h0fff_ffff);
        alu_row(alu_sra, 5'd9, 5'd2, 5'd0, 1'b1, 32'h4, 32'hffff_ffff);
        alu_row(alu_or, 5'd10, 5'd1, 5'd4, 1'b0, 32'h0, 32'h55);
        alu_row(alu_and, 5'd11, 5'd2, 5'd0, 1'b1, 32'h0000_ff3c, 32'h0000_ff30);
        // write to x0 must not forward
        alu_row(alu_add, 5'd0, 5'd0, 5'd0, 1'b1, 32'h7, 32'h7);
        alu_row(alu_add, 5'd12, 5'd0, 5'd0, 1'b1, 32'h1, 32'h1);
        alu_row(alu_add, 5'd12, 5'd12, 5'd0, 1'b1, 32'h2, 32'h3);
        // both younger stages hold x12, newest is 3
        cmp_row(beq, 5'd13, 5'd12, 5'd0, 1'b1, 32'h3, 1'b1);
        cmp_row(bne, 5'd14, 5'd1, 5'd4, 1'b0, 32'h0, 1'b1);
        cmp_row(blt, 5'd15, 5'd2, 5'd1, 1'b0, 32'h0, 1'b1);
        cmp_row(bge, 5'd16, 5'd2, 5'd1, 1'b0, 32'h0, 1'b0);
        cmp_row(bltu, 5'd17, 5'd2, 5'd1, 1'b0, 32'h0, 1'b0);
        cmp_row(bgeu, 5'd18, 5'd2, 5'd1, 1'b0, 32'h0, 1'b1);
        link_row(5'd19);
        store_row(sb, 5'd4, 5'd7, 32'h1, 32'h50, 4'b0010, 32'h0000_fa00);
        store_row(sb, 5'd4, 5'd7, 32'h3, 32'h50, 4'b1000, 32'hfa00_0000);
        store_row(sb, 5'd4, 5'd7, 32'h2, 32'h50, 4'b0100, 32'h00fa_0000);
        store_row(sb, 5'd4, 5'd7, 32'h0, 32'h50, 4'b0001, 32'h0000_00fa);
        store_row(sh, 5'd4, 5'd11, 32'h2, 32'h50, 4'b1100, 32'hff30_0000);
        store_row(sh, 5'd4, 5'd11, 32'h0, 32'h50, 4'b0011, 32'h0000_ff30);
        store_row(sw, 5'd4, 5'd1, 32'h4, 32'h54, 4'b1111, 32'h0000_0005);
        load_row(lw, 5'd20, 5'd4, 32'h8, 32'h58, 4'b1111);
        load_row(lbu, 5'd20, 5'd4, 32'h3, 32'h50, 4'b1000);
        load_row(lh, 5'd20, 5'd4, 32'h6, 32'h54, 4'b1100);
        // x20 was only a load target, so it still reads zero
        alu_row(alu_add, 5'd21, 5'd20, 5'd0, 1'b1, 32'h9, 32'h9);
    endtask

    task automatic drive_row(input int i);
        op_valid     <= 1'b1;
        op_pc        <= rows[i].pc;
        op_rs1       <= rows[i].rs1;
        op_rs2       <= rows[i].rs2;
        op_rd        <= rows[i].rd;
        op_imm       <= rows[i].imm;
        op_aluop     <= rows[i].aluop;
        op_cmpop     <= rows[i].cmpop;
        op_alu_a_sel <= rows[i].a_sel;
        op_alu_b_sel <= rows[i].b_sel;
        op_cmp_sel   <= rows[i].c_sel;
        op_mem_we    <= rows[i].mem_we;
        op_mem_re    <= rows[i].mem_re;
        op_funct3    <= rows[i].funct3;
        op_rd_sel    <= rows[i].rd_sel;
        op_rd_we     <= rows[i].rd_we;
        exp_push     <= 1'b1;
        exp_dmem     <= rows[i].e_dmem;
        exp_addr     <= rows[i].e_addr;
        exp_rmask    <= rows[i].e_rmask;
        exp_wmask    <= rows[i].e_wmask;
        exp_wdata    <= rows[i].e_wdata;
        exp_wb       <= rows[i].e_wb;
        exp_rd       <= rows[i].rd;
        exp_wbdata   <= rows[i].e_wbdata;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, operations still pending", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed = 32'hcf43;
        cycles = 0;
        n_rows = 0;
        limit = 1000;
        reset = 1'b1;
        move = 1'b0;
        op_valid = 1'b0;
        op_pc = '0;
        op_rs1 = '0;
        op_rs2 = '0;
        op_rd = '0;
        op_imm = '0;
        op_aluop = alu_add;
        op_cmpop = beq;
        op_alu_a_sel = rs1_out;
        op_alu_b_sel = rs2_out;
        op_cmp_sel = rs2_out_cmp;
        op_mem_we = 1'b0;
        op_mem_re = 1'b0;
        op_funct3 = '0;
        op_rd_sel = imm_rd;
        op_rd_we = 1'b0;
        exp_push = 1'b0;
        exp_dmem = 1'b0;
        exp_addr = '0;
        exp_rmask = '0;
        exp_wmask = '0;
        exp_wdata = '0;
        exp_wb = 1'b0;
        exp_rd = '0;
        exp_wbdata = '0;
        build_table();
        limit = n_rows * 8 + 40;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_rows; i++) begin
            drive_row(i);
            // hold the row until an edge with move high
            do begin
                @(posedge clk);
                accepted = move;
                move <= ($random(seed) % 4) != 0;
            end while (!accepted);
        end
        op_valid <= 1'b0;
        exp_push <= 1'b0;

        do begin
            @(posedge clk);
            move <= ($random(seed) % 4) != 0;
            @(negedge clk);
        end while (!idle);

        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src.f
src/rv32i_types.sv
src/stage_reg.sv
src/regfile.sv
src/forward_unit.sv
src/alu.sv
src/cmp.sv
src/ex_stage.sv
src/ex_top.sv
sim/ex_assertions.sv
sim/ex_checker.sv
sim/ex_tb.sv

//--- src/alu.sv
/* shift amount comes from the low five bits of b */
module alu (
    input  rv32i_types::alu_op_t         aluop,
    input  logic [rv32i_types::xlen-1:0] a,
    input  logic [rv32i_types::xlen-1:0] b,
    output logic [rv32i_types::xlen-1:0] aluout
);
    import rv32i_types::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        unique case (aluop)
            alu_add:  aluout = a + b;
            alu_sub:  aluout = a - b;
            alu_sll:  aluout = a << shamt;
            alu_slt:  aluout = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: aluout = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  aluout = a ^ b;
            alu_srl:  aluout = a >> shamt;
            alu_sra:  aluout = $unsigned($signed(a) >>> shamt);
            alu_or:   aluout = a | b;
            alu_and:  aluout = a & b;
            default:  aluout = '0;
        endcase
    end

endmodule

//--- src/cmp.sv
/* branch condition only; redirection is handled elsewhere */
module cmp (
    input  rv32i_types::cmp_op_t         cmpop,
    input  logic [rv32i_types::xlen-1:0] a,
    input  logic [rv32i_types::xlen-1:0] b,
    output logic                         br_en
);
    import rv32i_types::*;

    always_comb begin
        unique case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = ($signed(a) < $signed(b));
            bge:     br_en = ($signed(a) >= $signed(b));
            bltu:    br_en = (a < b);
            bgeu:    br_en = (a >= b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

//--- src/ex_stage.sv
/* purely combinational; loads only raise a read request and never write back.
   halfword accesses use the lane given by address bit 1, words ignore the low bits */
module ex_stage (
    input  rv32i_types::id_ex_reg_t      id_ex,
    input  logic [rv32i_types::xlen-1:0] reg_rs1_v,
    input  logic [rv32i_types::xlen-1:0] reg_rs2_v,
    input  rv32i_types::ex_mem_reg_t     ex_mem_curr,
    input  logic [rv32i_types::xlen-1:0] wb_data_curr,
    input  rv32i_types::forward_sel_t    forward_a,
    input  rv32i_types::forward_sel_t    forward_b,
    output rv32i_types::ex_mem_reg_t     ex_mem
);
    import rv32i_types::*;

    logic [xlen-1:0] rs1_v;
    logic [xlen-1:0] rs2_v;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] cmp_b;
    logic [xlen-1:0] alu_out;
    logic            br_en;
    logic [1:0]      offset;
    logic            do_store;
    logic            do_load;
    logic [3:0]      wmask;
    logic [3:0]      rmask;
    logic [xlen-1:0] wdata;

    // operand forwarding
    always_comb begin
        unique case (forward_a)
            mem_ex:  rs1_v = wb_value(ex_mem_curr);
            wb_ex:   rs1_v = wb_data_curr;
            default: rs1_v = reg_rs1_v;
        endcase
        unique case (forward_b)
            mem_ex:  rs2_v = wb_value(ex_mem_curr);
            wb_ex:   rs2_v = wb_data_curr;
            default: rs2_v = reg_rs2_v;
        endcase
    end

    always_comb begin
        unique case (id_ex.alu_a_sel)
            pc_out:  alu_a = id_ex.pc;
            default: alu_a = rs1_v;
        endcase
        unique case (id_ex.alu_b_sel)
            imm_out: alu_b = id_ex.imm;
            const4:  alu_b = 32'd4;
            default: alu_b = rs2_v;
        endcase
        unique case (id_ex.cmp_sel)
            imm_out_cmp: cmp_b = id_ex.imm;
            default:     cmp_b = rs2_v;
        endcase
    end

    alu u_alu (
        .aluop  (id_ex.aluop),
        .a      (alu_a),
        .b      (alu_b),
        .aluout (alu_out)
    );

    cmp u_cmp (
        .cmpop (id_ex.cmpop),
        .a     (rs1_v),
        .b     (cmp_b),
        .br_en (br_en)
    );

    // bubbles must not raise a memory request
    assign do_store = id_ex.valid && id_ex.mem_we;
    assign do_load  = id_ex.valid && id_ex.mem_re && !id_ex.mem_we;
    assign offset   = alu_out[1:0];

    always_comb begin
        wmask = '0;
        rmask = '0;
        wdata = '0;
        if (do_store) begin
            unique case (id_ex.funct3)
                sb: begin
                    wmask = 4'b0001 << offset;
                    wdata[8*offset +: 8] = rs2_v[7:0];
                end
                sh: begin
                    wmask = 4'b0011 << {offset[1], 1'b0};
                    wdata[16*offset[1] +: 16] = rs2_v[15:0];
                end
                sw: begin
                    wmask = 4'b1111;
                    wdata = rs2_v;
                end
                default: wmask = '0;
            endcase
        end else if (do_load) begin
            unique case (id_ex.funct3)
                lb, lbu: rmask = 4'b0001 << offset;
                lh, lhu: rmask = 4'b0011 << {offset[1], 1'b0};
                lw:      rmask = 4'b1111;
                default: rmask = '0;
            endcase
        end
    end

    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.rd         = id_ex.rd;
        ex_mem.rd_we      = id_ex.rd_we && !id_ex.mem_re;
        ex_mem.rd_sel     = id_ex.rd_sel;
        ex_mem.imm        = id_ex.imm;
        ex_mem.alu_out    = alu_out;
        ex_mem.br_en      = br_en;
        ex_mem.dmem_addr  = {alu_out[xlen-1:2], 2'b00};
        ex_mem.dmem_rmask = rmask;
        ex_mem.dmem_wmask = wmask;
        ex_mem.dmem_wdata = wdata;
    end

endmodule

//--- src/ex_top.sv
/* every register advances only on move; a dmem request shows one edge after
   acceptance, write-back two. wb_valid marks real register writes */
module ex_top #(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         move,
    input  logic                         op_valid,
    input  logic [rv32i_types::xlen-1:0] op_pc,
    input  rv32i_types::reg_addr_t       op_rs1,
    input  rv32i_types::reg_addr_t       op_rs2,
    input  rv32i_types::reg_addr_t       op_rd,
    input  logic [rv32i_types::xlen-1:0] op_imm,
    input  rv32i_types::alu_op_t         op_aluop,
    input  rv32i_types::cmp_op_t         op_cmpop,
    input  rv32i_types::alu_a_sel_t      op_alu_a_sel,
    input  rv32i_types::alu_b_sel_t      op_alu_b_sel,
    input  rv32i_types::cmp_b_sel_t      op_cmp_sel,
    input  logic                         op_mem_we,
    input  logic                         op_mem_re,
    input  logic [2:0]                   op_funct3,
    input  rv32i_types::rd_sel_t         op_rd_sel,
    input  logic                         op_rd_we,
    output logic                         dmem_valid,
    output logic [rv32i_types::xlen-1:0] dmem_addr,
    output logic [3:0]                   dmem_rmask,
    output logic [3:0]                   dmem_wmask,
    output logic [rv32i_types::xlen-1:0] dmem_wdata,
    output logic                         wb_valid,
    output rv32i_types::reg_addr_t       wb_rd,
    output logic [rv32i_types::xlen-1:0] wb_data
);
    import rv32i_types::*;

    id_ex_reg_t      id_ex_d;
    id_ex_reg_t      id_ex_q;
    ex_mem_reg_t     ex_mem_d;
    ex_mem_reg_t     ex_mem_q;
    mem_wb_reg_t     mem_wb_d;
    mem_wb_reg_t     mem_wb_q;
    logic [xlen-1:0] rs1_rdata;
    logic [xlen-1:0] rs2_rdata;
    forward_sel_t    forward_a;
    forward_sel_t    forward_b;
    logic            rf_we;

    assign id_ex_d = '{
        valid:     op_valid,
        pc:        op_pc,
        rs1:       op_rs1,
        rs2:       op_rs2,
        rd:        op_rd,
        imm:       op_imm,
        aluop:     op_aluop,
        cmpop:     op_cmpop,
        alu_a_sel: op_alu_a_sel,
        alu_b_sel: op_alu_b_sel,
        cmp_sel:   op_cmp_sel,
        mem_we:    op_mem_we,
        mem_re:    op_mem_re,
        funct3:    op_funct3,
        rd_sel:    op_rd_sel,
        rd_we:     op_rd_we
    };

    stage_reg #(.payload_t(id_ex_reg_t)) u_id_ex (
        .clk   (clk),
        .reset (reset),
        .move  (move),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    regfile #(.reg_count(reg_count)) u_regfile (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (mem_wb_q.rd),
        .wdata  (mem_wb_q.wb_data),
        .raddr1 (id_ex_q.rs1),
        .raddr2 (id_ex_q.rs2),
        .rdata1 (rs1_rdata),
        .rdata2 (rs2_rdata)
    );

    forward_unit u_forward_unit (
        .rs1       (id_ex_q.rs1),
        .rs2       (id_ex_q.rs2),
        .ex_mem_rd (ex_mem_q.rd),
        .mem_wb_rd (mem_wb_q.rd),
        .ex_mem_wr (ex_mem_q.valid && ex_mem_q.rd_we),
        .mem_wb_wr (mem_wb_q.valid && mem_wb_q.rd_we),
        .forward_a (forward_a),
        .forward_b (forward_b)
    );

    ex_stage u_ex_stage (
        .id_ex        (id_ex_q),
        .reg_rs1_v    (rs1_rdata),
        .reg_rs2_v    (rs2_rdata),
        .ex_mem_curr  (ex_mem_q),
        .wb_data_curr (mem_wb_q.wb_data),
        .forward_a    (forward_a),
        .forward_b    (forward_b),
        .ex_mem       (ex_mem_d)
    );

    stage_reg #(.payload_t(ex_mem_reg_t)) u_ex_mem (
        .clk   (clk),
        .reset (reset),
        .move  (move),
        .d     (ex_mem_d),
        .q     (ex_mem_q)
    );

    // write-back value chosen by rd_sel
    assign mem_wb_d = '{
        valid:   ex_mem_q.valid,
        rd:      ex_mem_q.rd,
        rd_we:   ex_mem_q.rd_we,
        wb_data: wb_value(ex_mem_q)
    };

    stage_reg #(.payload_t(mem_wb_reg_t)) u_mem_wb (
        .clk   (clk),
        .reset (reset),
        .move  (move),
        .d     (mem_wb_d),
        .q     (mem_wb_q)
    );

    assign rf_we = move && wb_valid;

    assign dmem_valid = ex_mem_q.valid && (ex_mem_q.dmem_rmask != '0 || ex_mem_q.dmem_wmask != '0);
    assign dmem_addr  = ex_mem_q.dmem_addr;
    assign dmem_rmask = ex_mem_q.dmem_rmask;
    assign dmem_wmask = ex_mem_q.dmem_wmask;
    assign dmem_wdata = ex_mem_q.dmem_wdata;
    assign wb_valid   = mem_wb_q.valid && mem_wb_q.rd_we;
    assign wb_rd      = mem_wb_q.rd;
    assign wb_data    = mem_wb_q.wb_data;

endmodule

//--- src/forward_unit.sv
/* write flags must already include the stage valid; the EX/MEM match wins over MEM/WB */
module forward_unit (
    input  rv32i_types::reg_addr_t    rs1,
    input  rv32i_types::reg_addr_t    rs2,
    input  rv32i_types::reg_addr_t    ex_mem_rd,
    input  rv32i_types::reg_addr_t    mem_wb_rd,
    input  logic                      ex_mem_wr,
    input  logic                      mem_wb_wr,
    output rv32i_types::forward_sel_t forward_a,
    output rv32i_types::forward_sel_t forward_b
);
    import rv32i_types::*;

    function automatic forward_sel_t pick(reg_addr_t rs);
        forward_sel_t sel;
        sel = none;
        if (rs != '0) begin
            if (ex_mem_wr && ex_mem_rd == rs) begin
                sel = mem_ex;
            end else if (mem_wb_wr && mem_wb_rd == rs) begin
                sel = wb_ex;
            end
        end
        return sel;
    endfunction

    assign forward_a = pick(rs1);
    assign forward_b = pick(rs2);

endmodule

//--- src/regfile.sv
/* two combinational reads, one write per edge; no read bypass, so a write
   becomes visible only after the edge. x0 always reads zero */
module regfile #(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we,
    input  rv32i_types::reg_addr_t       waddr,
    input  logic [rv32i_types::xlen-1:0] wdata,
    input  rv32i_types::reg_addr_t       raddr1,
    input  rv32i_types::reg_addr_t       raddr2,
    output logic [rv32i_types::xlen-1:0] rdata1,
    output logic [rv32i_types::xlen-1:0] rdata2
);
    import rv32i_types::*;

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- src/rv32i_types.sv
/* shared widths, encodings and pipeline records for the RV32I execute slice
   funct3 codes follow the ISA; load and store codes overlap, so they live in two enums */
package rv32i_types;

    localparam int xlen = 32;

    typedef logic [4:0] reg_addr_t;

    // funct7[5] joined with funct3
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {
        rs1_out = 1'b0,
        pc_out  = 1'b1
    } alu_a_sel_t;

    typedef enum logic [1:0] {
        rs2_out = 2'b00,
        imm_out = 2'b01,
        const4  = 2'b10
    } alu_b_sel_t;

    typedef enum logic {
        rs2_out_cmp = 1'b0,
        imm_out_cmp = 1'b1
    } cmp_b_sel_t;

    // write-back source
    typedef enum logic [1:0] {
        imm_rd     = 2'b00,
        alu_out_rd = 2'b01,
        ext_br     = 2'b10
    } rd_sel_t;

    typedef enum logic [1:0] {
        none   = 2'b00,
        mem_ex = 2'b01,
        wb_ex  = 2'b10
    } forward_sel_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        reg_addr_t       rs1;
        reg_addr_t       rs2;
        reg_addr_t       rd;
        logic [xlen-1:0] imm;
        alu_op_t         aluop;
        cmp_op_t         cmpop;
        alu_a_sel_t      alu_a_sel;
        alu_b_sel_t      alu_b_sel;
        cmp_b_sel_t      cmp_sel;
        logic            mem_we;
        logic            mem_re;
        logic [2:0]      funct3;
        rd_sel_t         rd_sel;
        logic            rd_we;
    } id_ex_reg_t;

    typedef struct packed {
        logic            valid;
        reg_addr_t       rd;
        logic            rd_we;
        rd_sel_t         rd_sel;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] alu_out;
        logic            br_en;
        logic [xlen-1:0] dmem_addr;
        logic [3:0]      dmem_rmask;
        logic [3:0]      dmem_wmask;
        logic [xlen-1:0] dmem_wdata;
    } ex_mem_reg_t;

    typedef struct packed {
        logic            valid;
        reg_addr_t       rd;
        logic            rd_we;
        logic [xlen-1:0] wb_data;
    } mem_wb_reg_t;

    // value an EX/MEM entry will write back, also the mem_ex forward value
    function automatic logic [xlen-1:0] wb_value(ex_mem_reg_t r);
        logic [xlen-1:0] v;
        unique case (r.rd_sel)
            imm_rd:     v = r.imm;
            alu_out_rd: v = r.alu_out;
            ext_br:     v = {{(xlen-1){1'b0}}, r.br_en};
            default:    v = '0;
        endcase
        return v;
    endfunction

endpackage

//--- src/stage_reg.sv
/* pipeline boundary register; holds when move is low, clears to all zero on reset */
module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     move,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (move) begin
            q <= d;
        end
    end

endmodule
